// File: src/mem_pkg.sv
// shared widths, request/response structs and the grant encoding
// for the single-port memory system.
// data addresses are word addresses; a byte address is {addr, 2'b00}
// RAM decodes only log2(RAM_WORDS) word bits, so higher addresses alias
`default_nettype none

package mem_pkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////

	localparam int WB_DEPTH   = 4;
	localparam int WB_IDX_W   = $clog2(WB_DEPTH);
	// extra bit tells full from empty
	localparam int WB_PTR_W   = WB_IDX_W + 1;
	localparam int RAM_WORDS  = 1024;
	localparam int RAM_ADDR_W = $clog2(RAM_WORDS);

	typedef logic [31:0] word_t;
	typedef logic [13:0] daddr_t;
	typedef logic [2:0]  lq_index_t;

	//////////////////////////////////////////////////
	// port bundles
	//////////////////////////////////////////////////

	// data read, tagged with the load queue slot
	typedef struct packed {
		logic      valid;
		lq_index_t lq_index;
		daddr_t    addr;
	} dread_req_t;

	// answered one cycle after the request
	typedef struct packed {
		logic      valid;
		lq_index_t lq_index;
		word_t     data;
	} dread_resp_t;

	// posted store, also the write buffer entry
	typedef struct packed {
		logic   valid;
		daddr_t addr;
		word_t  data;
	} dwrite_req_t;

	// instruction fetch, byte address
	typedef struct packed {
		logic  ren;
		word_t addr;
	} ifetch_req_t;

	// one RAM access, byte address
	typedef struct packed {
		logic  ren;
		logic  wen;
		word_t addr;
		word_t store;
	} ram_port_t;

	// testbench takeover of the RAM
	typedef struct packed {
		logic  ctrl;
		logic  ren;
		logic  wen;
		word_t addr;
		word_t store;
	} tb_ram_t;

	// who owns the RAM this cycle
	typedef enum logic [1:0] {
		GRANT_NONE,
		GRANT_DREAD,
		GRANT_DRAIN,
		GRANT_IFETCH
	} mem_grant_e;

endpackage

`default_nettype wire

// File: src/write_buffer.sv
// posted write FIFO of WB_DEPTH entries between the data port and RAM.
// a write enqueues when valid and not full; deq pops the head entry.
// lookup is combinational over occupied entries, youngest match wins.
// writes enqueued this cycle are not visible to the lookup until the edge
`default_nettype none

module write_buffer (
	input  logic                  CLK,
	input  logic                  nRST,
	input  mem_pkg::dwrite_req_t  wr,
	input  logic                  deq,
	input  mem_pkg::daddr_t       lookup_addr,
	output mem_pkg::dwrite_req_t  head,
	output logic                  fwd_hit,
	output mem_pkg::word_t        fwd_data,
	output logic                  full,
	output logic                  empty
);
	import mem_pkg::*;

	// entry storage, payload only
	dwrite_req_t entries [WB_DEPTH];

	// pointers carry a wrap bit above the index
	logic [WB_PTR_W-1:0] head_ptr;
	logic [WB_PTR_W-1:0] tail_ptr;
	logic [WB_PTR_W-1:0] count;
	logic [WB_IDX_W-1:0] head_idx;
	logic [WB_IDX_W-1:0] tail_idx;
	logic [WB_IDX_W-1:0] slot;
	logic                enq;

	assign head_idx = head_ptr[WB_IDX_W-1:0];
	assign tail_idx = tail_ptr[WB_IDX_W-1:0];
	assign count    = tail_ptr - head_ptr;

	//////////////////////////////////////////////////
	// status
	//////////////////////////////////////////////////

	assign empty = (head_ptr == tail_ptr);
	// same slot, different lap
	assign full = (head_idx == tail_idx) &&
		(head_ptr[WB_PTR_W-1] != tail_ptr[WB_PTR_W-1]);
	assign enq = wr.valid && !full;

	//////////////////////////////////////////////////
	// pointers and storage
	//////////////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			head_ptr <= '0;
			tail_ptr <= '0;
		end
		else
		begin
			if (enq)
				tail_ptr <= tail_ptr + 1'b1;
			if (deq)
				head_ptr <= head_ptr + 1'b1;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (enq)
			entries[tail_idx] <= wr;
	end

	// oldest entry, valid only while occupied
	always_comb
	begin
		head = entries[head_idx];
		head.valid = !empty;
	end

	//////////////////////////////////////////////////
	// forwarding search
	//////////////////////////////////////////////////

	// walk oldest to youngest so a later match overrides
	always_comb
	begin
		fwd_hit = 1'b0;
		fwd_data = '0;
		slot = head_idx;
		for (int k = 0; k < WB_DEPTH; k++)
		begin
			slot = head_idx + WB_IDX_W'(k);
			if ((WB_PTR_W'(k) < count) && (entries[slot].addr == lookup_addr))
			begin
				fwd_hit = 1'b1;
				fwd_data = entries[slot].data;
			end
		end
	end

	// occupancy never passes the depth
	a_no_enq_full: assert property (@(posedge CLK) disable iff (!nRST)
		count <= WB_DEPTH)
		else $error("write buffer overfilled");

	// arbiter must not drain an empty buffer
	a_no_deq_empty: assert property (@(posedge CLK) disable iff (!nRST)
		deq |-> !empty)
		else $error("write buffer dequeued while empty");

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
// fixed priority owner of the RAM: data read, then drain, then fetch.
// a forwarded data read still takes the cycle but issues no RAM read,
// so a continuous read stream starves both drain and fetch.
// the grant and ifetch_hit are combinational; the read response is
// registered and appears exactly one cycle after the request
`default_nettype none

module mem_arbiter (
	input  logic                  CLK,
	input  logic                  nRST,
	input  mem_pkg::dread_req_t   dread,
	input  logic                  fwd_hit,
	input  mem_pkg::word_t        fwd_data,
	input  mem_pkg::dwrite_req_t  head,
	input  mem_pkg::ifetch_req_t  ifetch,
	input  mem_pkg::word_t        ram_rdata,
	output mem_pkg::ram_port_t    ram,
	output logic                  deq,
	output logic                  ifetch_hit,
	output mem_pkg::dread_resp_t  dread_resp
);
	import mem_pkg::*;

	mem_grant_e grant;

	// response register
	logic      resp_valid;
	lq_index_t resp_lq;
	word_t     resp_data;
	word_t     next_data;

	//////////////////////////////////////////////////
	// grant
	//////////////////////////////////////////////////

	always_comb
	begin
		if (dread.valid)
			grant = GRANT_DREAD;
		else if (head.valid)
			grant = GRANT_DRAIN;
		else if (ifetch.ren)
			grant = GRANT_IFETCH;
		else
			grant = GRANT_NONE;
	end

	//////////////////////////////////////////////////
	// RAM access
	//////////////////////////////////////////////////

	always_comb
	begin
		ram = '0;
		// store data only matters on drain
		ram.store = head.data;
		deq = 1'b0;
		ifetch_hit = 1'b0;
		case (grant)
			GRANT_DREAD:
			begin
				// buffer hit, RAM stays idle
				ram.ren = !fwd_hit;
				ram.addr = word_t'({dread.addr, 2'b00});
			end
			GRANT_DRAIN:
			begin
				ram.wen = 1'b1;
				ram.addr = word_t'({head.addr, 2'b00});
				deq = 1'b1;
			end
			GRANT_IFETCH:
			begin
				ram.ren = 1'b1;
				ram.addr = ifetch.addr;
				ifetch_hit = 1'b1;
			end
			default:
			begin
				ram.ren = 1'b0;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// read response
	//////////////////////////////////////////////////

	// youngest buffered store beats RAM contents
	assign next_data = fwd_hit ? fwd_data : ram_rdata;

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
			resp_valid <= 1'b0;
		else
			resp_valid <= dread.valid;
	end

	// tag and data only load with a request
	always_ff @(posedge CLK)
	begin
		if (dread.valid)
		begin
			resp_lq <= dread.lq_index;
			resp_data <= next_data;
		end
	end

	always_comb
	begin
		dread_resp.valid = resp_valid;
		dread_resp.lq_index = resp_lq;
		dread_resp.data = resp_data;
	end

	// a forwarding hit implies an occupied buffer
	a_fwd_has_entry: assert property (@(posedge CLK) disable iff (!nRST)
		fwd_hit |-> head.valid)
		else $error("forwarding hit from an empty write buffer");

	// requester holds a fetch until it is served
	a_fetch_held: assert property (@(posedge CLK) disable iff (!nRST)
		(ifetch.ren && !ifetch_hit) |=> (ifetch.ren && $stable(ifetch.addr)))
		else $error("fetch request dropped before a hit");

endmodule

`default_nettype wire

// File: src/ram.sv
// word RAM of RAM_WORDS entries, not cleared by reset.
// byte address bits [1:0] are ignored and bits above the decoded
// range alias onto the same words.
// tb.ctrl hands the whole port to the testbench
`default_nettype none

module ram (
	input  logic               CLK,
	input  mem_pkg::ram_port_t sys,
	input  mem_pkg::tb_ram_t   tb,
	output mem_pkg::word_t     rdata
);
	import mem_pkg::*;

	word_t mem [RAM_WORDS];

	// port that owns the RAM this cycle
	ram_port_t sel;
	logic [RAM_ADDR_W-1:0] idx;

	always_comb
	begin
		if (tb.ctrl)
		begin
			sel.ren = tb.ren;
			sel.wen = tb.wen;
			sel.addr = tb.addr;
			sel.store = tb.store;
		end
		else
		begin
			sel = sys;
		end
	end

	// word index, drop byte offset
	assign idx = sel.addr[RAM_ADDR_W+1:2];

	always_ff @(posedge CLK)
	begin
		if (sel.wen)
			mem[idx] <= sel.store;
	end

	// async read, zero when nobody reads
	assign rdata = sel.ren ? mem[idx] : '0;

	a_sel_one_op: assert property (@(posedge CLK)
		!(sel.ren && sel.wen))
		else $error("RAM port read and write together");

endmodule

`default_nettype wire

// File: src/mem_system.sv
// memory side of a cacheless single core: data port, fetch port and
// a testbench RAM port share one word RAM.
// writes are posted into a small buffer; halt waits for it to drain.
// tb_ram.ctrl may only go high while the system side is idle and the
// write buffer is empty
`default_nettype none

module mem_system (
	input  logic                  CLK,
	input  logic                  nRST,
	input  mem_pkg::dread_req_t   dread,
	input  mem_pkg::dwrite_req_t  dwrite,
	input  mem_pkg::ifetch_req_t  ifetch,
	input  logic                  halt_req,
	input  mem_pkg::tb_ram_t      tb_ram,
	output mem_pkg::dread_resp_t  dread_resp,
	output logic                  write_blocked,
	output logic                  ifetch_hit,
	output mem_pkg::word_t        ifetch_load,
	output logic                  halt,
	output mem_pkg::word_t        tb_load
);
	import mem_pkg::*;

	// buffer to arbiter
	dwrite_req_t wb_head;
	logic        wb_fwd_hit;
	word_t       wb_fwd_data;
	logic        wb_full;
	logic        wb_empty;
	logic        wb_deq;

	// arbiter to RAM
	ram_port_t ram_req;
	word_t     ram_rdata;

	//////////////////////////////////////////////////
	// blocks
	//////////////////////////////////////////////////

	write_buffer u_write_buffer (
		.CLK         (CLK),
		.nRST        (nRST),
		.wr          (dwrite),
		.deq         (wb_deq),
		.lookup_addr (dread.addr),
		.head        (wb_head),
		.fwd_hit     (wb_fwd_hit),
		.fwd_data    (wb_fwd_data),
		.full        (wb_full),
		.empty       (wb_empty)
	);

	mem_arbiter u_mem_arbiter (
		.CLK        (CLK),
		.nRST       (nRST),
		.dread      (dread),
		.fwd_hit    (wb_fwd_hit),
		.fwd_data   (wb_fwd_data),
		.head       (wb_head),
		.ifetch     (ifetch),
		.ram_rdata  (ram_rdata),
		.ram        (ram_req),
		.deq        (wb_deq),
		.ifetch_hit (ifetch_hit),
		.dread_resp (dread_resp)
	);

	ram u_ram (
		.CLK   (CLK),
		.sys   (ram_req),
		.tb    (tb_ram),
		.rdata (ram_rdata)
	);

	//////////////////////////////////////////////////
	// outputs
	//////////////////////////////////////////////////

	assign write_blocked = wb_full;
	assign ifetch_load = ram_rdata;
	assign tb_load = ram_rdata;

	// posted stores must reach RAM before halt is reported
	assign halt = halt_req && wb_empty;

endmodule

`default_nettype wire

// File: tests/mem_system_tb.sv
// testbench for the memory system.
// preloads RAM through the tb port, then runs data reads, posted writes,
// fetches and halt. Concurrent assertions compare against a word model.
// only word addresses below AREA are used, so RAM aliasing never matters
`default_nettype none

module mem_system_tb;
	import mem_pkg::*;

	localparam int CYCLE_LIMIT = 40;
	// preloaded window
	localparam int AREA = 64;

	logic        CLK;
	logic        nRST;
	dread_req_t  dread;
	dwrite_req_t dwrite;
	ifetch_req_t ifetch;
	logic        halt_req;
	tb_ram_t     tb_ram;
	dread_resp_t dread_resp;
	logic        write_blocked;
	logic        ifetch_hit;
	word_t       ifetch_load;
	logic        halt;
	word_t       tb_load;

	// reference memory and buffer occupancy
	word_t model [RAM_WORDS];
	int    pending;
	logic  wr_accepted;
	logic  fetch_seen;
	word_t exp_rd;
	word_t exp_fetch;
	word_t exp_dump;
	int    errors;
	int    errors_at_start;
	int    tests_run;
	int    i;
	string test_name;

	mem_system u_mem_system (
		.CLK           (CLK),
		.nRST          (nRST),
		.dread         (dread),
		.dwrite        (dwrite),
		.ifetch        (ifetch),
		.halt_req      (halt_req),
		.tb_ram        (tb_ram),
		.dread_resp    (dread_resp),
		.write_blocked (write_blocked),
		.ifetch_hit    (ifetch_hit),
		.ifetch_load   (ifetch_load),
		.halt          (halt),
		.tb_load       (tb_load)
	);

	always #10 CLK = ~CLK;

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	always @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			pending <= 0;
			wr_accepted <= 1'b0;
			fetch_seen <= 1'b0;
		end
		else
		begin
			// enqueue while room, drain whenever no data read
			pending <= pending + int'(dwrite.valid && pending < WB_DEPTH)
				- int'(pending > 0 && !dread.valid);
			wr_accepted <= dwrite.valid && pending < WB_DEPTH;
			fetch_seen <= ifetch_hit;
			if (dwrite.valid && pending < WB_DEPTH)
				model[dwrite.addr[RAM_ADDR_W-1:0]] <= dwrite.data;
			if (tb_ram.ctrl && tb_ram.wen)
				model[tb_ram.addr[RAM_ADDR_W+1:2]] <= tb_ram.store;
		end
	end

	// reads see only writes from earlier edges
	assign exp_rd = model[dread.addr[RAM_ADDR_W-1:0]];
	assign exp_fetch = model[ifetch.addr[RAM_ADDR_W+1:2]];
	assign exp_dump = model[tb_ram.addr[RAM_ADDR_W+1:2]];

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	a_read_resp: assert property (@(posedge CLK) disable iff (!nRST)
		dread.valid |=> (dread_resp.valid && dread_resp.lq_index == $past(dread.lq_index)
			&& dread_resp.data == $past(exp_rd)))
		else report_mismatch("data read response has wrong tag or data");

	a_no_resp: assert property (@(posedge CLK) disable iff (!nRST)
		!dread.valid |=> !dread_resp.valid)
		else report_mismatch("data read response without a request");

	a_blocked: assert property (@(posedge CLK) disable iff (!nRST)
		write_blocked == (pending == WB_DEPTH))
		else report_mismatch("write_blocked does not match buffer occupancy");

	// fetch only on a RAM cycle nobody else wants
	a_fetch_idle: assert property (@(posedge CLK) disable iff (!nRST)
		ifetch_hit |-> (ifetch.ren && !dread.valid && pending == 0))
		else report_mismatch("ifetch_hit while data side busy");

	a_fetch_data: assert property (@(posedge CLK) disable iff (!nRST)
		ifetch_hit |-> (ifetch_load == exp_fetch))
		else report_mismatch("ifetch_load differs from memory");

	a_halt: assert property (@(posedge CLK) disable iff (!nRST)
		halt == (halt_req && pending == 0))
		else report_mismatch("halt does not follow halt_req and empty buffer");

	a_dump: assert property (@(posedge CLK) disable iff (!nRST)
		(tb_ram.ctrl && tb_ram.ren) |-> (tb_load == exp_dump))
		else report_mismatch("tb_load differs from memory");

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task report_mismatch(input string msg);
		errors++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	task report_timeout(input string msg);
		errors++;
		$display("timeout at %0t: %s", $time, msg);
	endtask

	task begin_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task finish_test;
		tests_run++;
		$display("test %0d %s finished with %0d errors", tests_run, test_name,
			errors - errors_at_start);
	endtask

	task wait_accept;
		int n;
		n = 0;
		do
		begin
			@(negedge CLK);
			n++;
		end
		while (!wr_accepted && n < CYCLE_LIMIT);
		if (!wr_accepted)
			report_timeout("posted write was never accepted");
	endtask

	task write_word(input daddr_t a, input word_t d);
		dwrite = '{valid: 1'b1, addr: a, data: d};
		wait_accept();
		dwrite.valid = 1'b0;
	endtask

	task wait_fetch;
		int n;
		n = 0;
		do
		begin
			@(negedge CLK);
			n++;
		end
		while (!fetch_seen && n < CYCLE_LIMIT);
		if (!fetch_seen)
			report_timeout("fetch was never granted");
	endtask

	task fetch_word(input daddr_t a);
		ifetch = '{ren: 1'b1, addr: {16'h0, a, 2'b00}};
		wait_fetch();
		ifetch.ren = 1'b0;
	endtask

	// halt doubles as the drained indicator
	task wait_drained;
		int n;
		halt_req = 1'b1;
		n = 0;
		do
		begin
			@(negedge CLK);
			n++;
		end
		while (!halt && n < CYCLE_LIMIT);
		if (!halt)
			report_timeout("write buffer never drained");
		halt_req = 1'b0;
	endtask

	task read_word(input lq_index_t tag, input daddr_t a);
		dread = '{valid: 1'b1, lq_index: tag, addr: a};
		@(negedge CLK);
		dread.valid = 1'b0;
	endtask

	task preload_word(input daddr_t a, input word_t d);
		tb_ram = '{ctrl: 1'b1, ren: 1'b0, wen: 1'b1, addr: {16'h0, a, 2'b00}, store: d};
		@(negedge CLK);
	endtask

	task dump_word(input daddr_t a);
		tb_ram = '{ctrl: 1'b1, ren: 1'b1, wen: 1'b0, addr: {16'h0, a, 2'b00}, store: '0};
		@(negedge CLK);
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	initial
	begin
		CLK = 1'b0;
		nRST = 1'b0;
		dread = '0;
		dwrite = '0;
		ifetch = '0;
		halt_req = 1'b0;
		tb_ram = '0;
		errors = 0;
		tests_run = 0;
		void'($urandom(22948));
		repeat (4) @(negedge CLK);
		nRST = 1'b1;

		begin_test("preload and fetch");
		for (i = 0; i < AREA; i++)
			preload_word(daddr_t'(i), $urandom);
		tb_ram = '0;
		for (i = 32; i < 40; i++)
			fetch_word(daddr_t'(i));
		finish_test();

		begin_test("write then read");
		write_word(14'd3, $urandom);
		// forwarded from the buffer
		read_word(3'd1, 14'd3);
		// unrelated read holds both stores to 5 in the buffer
		dread = '{valid: 1'b1, lq_index: 3'd0, addr: 14'd10};
		write_word(14'd5, $urandom);
		write_word(14'd5, $urandom);
		read_word(3'd2, 14'd5);
		wait_drained();
		// now straight from RAM
		read_word(3'd4, 14'd3);
		read_word(3'd5, 14'd5);
		finish_test();

		begin_test("buffer full");
		dread = '{valid: 1'b1, lq_index: 3'd6, addr: 14'd7};
		for (i = 0; i < WB_DEPTH; i++)
			write_word(daddr_t'(16 + i), $urandom);
		// fifth store stays blocked while reads hold the RAM
		dwrite = '{valid: 1'b1, addr: 14'd20, data: $urandom};
		repeat (3) @(negedge CLK);
		dread.valid = 1'b0;
		wait_accept();
		dwrite.valid = 1'b0;
		wait_drained();
		finish_test();

		begin_test("fetch priority");
		dread = '{valid: 1'b1, lq_index: 3'd3, addr: 14'd8};
		write_word(14'd24, $urandom);
		write_word(14'd25, $urandom);
		// fetch of a buffered address must wait for the drain
		ifetch = '{ren: 1'b1, addr: {16'h0, 14'd24, 2'b00}};
		repeat (4) @(negedge CLK);
		dread.valid = 1'b0;
		wait_fetch();
		ifetch.ren = 1'b0;
		finish_test();

		begin_test("halt and dump");
		halt_req = 1'b1;
		dread = '{valid: 1'b1, lq_index: 3'd7, addr: 14'd2};
		write_word(14'd30, $urandom);
		write_word(14'd31, $urandom);
		write_word(14'd3, $urandom);
		repeat (2) @(negedge CLK);
		dread.valid = 1'b0;
		wait_drained();
		for (i = 0; i < AREA; i++)
			dump_word(daddr_t'(i));
		tb_ram = '0;
		finish_test();

		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
src/mem_pkg.sv
src/write_buffer.sv
src/mem_arbiter.sv
src/ram.sv
src/mem_system.sv
tests/mem_system_tb.sv
